// ==== rtl/frontend_pkg.sv ====
package frontend_pkg;

    // Fetch address width.
    localparam int addr_w = 32;
    // Bytes returned by one fetch reply.
    localparam int block_bytes = 16;
    // Capacity of the decode byte buffer.
    localparam int buf_bytes = 64;
    // Requests in flight never reserve more than the buffer holds.
    localparam int max_outstanding = buf_bytes / block_bytes;
    localparam int id_w = 8;
    // Holds a byte count from 0 to buf_bytes.
    localparam int count_w = 7;
    // Longest instruction.
    localparam int inst_bytes = 6;
    localparam int len_w = 3;
    localparam int queue_depth = 8;

    // One reply block, byte 0 in the low bits.
    typedef logic [block_bytes*8-1:0] block_t;

    // Decoded instruction as it sits in the instruction queue.
    // Bytes past the length are zero.
    typedef struct packed {
        logic [inst_bytes*8-1:0] data;
        logic [addr_w-1:0]       addr;
        logic [len_w-1:0]        len;
    } inst_t;

    // Class codes, low three bits of the first byte.
    localparam logic [2:0] class_alu  = 3'b100;
    localparam logic [2:0] class_mio  = 3'b010;
    localparam logic [2:0] class_pfcu = 3'b110;

    // Instruction lengths per class and format.
    localparam logic [len_w-1:0] len_alu_imm   = 3'd6;
    localparam logic [len_w-1:0] len_alu_reg   = 3'd2;
    localparam logic [len_w-1:0] len_mio_long  = 3'd6;
    localparam logic [len_w-1:0] len_mio_short = 3'd2;
    localparam logic [len_w-1:0] len_mio_mid   = 3'd3;
    localparam logic [len_w-1:0] len_pfcu_long = 3'd5;
    localparam logic [len_w-1:0] len_pfcu      = 3'd1;

endpackage

// ==== rtl/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
    parameter type item_t = logic [7:0],
    parameter int  depth  = 4
) (
    input  logic                         clk,
    input  logic                         ht_rst,
    input  logic                         flush,
    input  logic                         push,
    input  item_t                        wr_item,
    input  logic                         pop,
    output item_t                        rd_item,
    output logic                         full,
    output logic                         empty,
    output logic [$clog2(depth+1)-1:0]   count
);

    // Storage, no reset needed since count guards every read.
    item_t mem [depth];

    logic [$clog2(depth)-1:0] wr_ptr;
    logic [$clog2(depth)-1:0] rd_ptr;
    logic                     do_push;
    logic                     do_pop;

    // A push into a full FIFO or a pop from an empty one is dropped.
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign full    = (count == ($clog2(depth+1))'(depth));
    assign empty   = (count == '0);

    // Head of the queue is always visible.
    assign rd_item = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wr_item;
        end
    end

    // Pointers wrap at depth - 1, so depth need not be a power of two.
    always_ff @(posedge clk) begin
        if (ht_rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ($clog2(depth))'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ($clog2(depth))'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leave the count alone.
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== rtl/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit (
    input  logic                             clk,
    input  logic                             ht_rst,
    input  logic [frontend_pkg::addr_w-1:0]  pc,
    input  logic                             redirect,
    input  logic [frontend_pkg::count_w-1:0] byte_count,
    output logic                             req_valid,
    output logic [frontend_pkg::addr_w-1:0]  req_addr,
    output logic [frontend_pkg::id_w-1:0]    req_id,
    input  logic                             req_accept,
    input  logic                             rsp_valid,
    input  logic [frontend_pkg::id_w-1:0]    rsp_id,
    input  frontend_pkg::block_t             rsp_data,
    output logic                             blk_write,
    output frontend_pkg::block_t             blk_data
);

    logic [frontend_pkg::addr_w-1:0] fetch_addr;
    logic [frontend_pkg::id_w-1:0]   next_id;
    // Low for one cycle after reset or redirect so the new pc is settled.
    logic                            started;

    // Request log signals.
    logic                                               log_push;
    logic                                               log_pop;
    logic [frontend_pkg::id_w-1:0]                      log_head;
    logic                                               log_empty;
    logic [$clog2(frontend_pkg::max_outstanding+1)-1:0] log_count;

    // Bytes held plus bytes reserved plus the next block.
    logic [frontend_pkg::count_w:0] need;
    logic                           space_ok;

    // One spare bit so the sum never wraps.
    assign need = (frontend_pkg::count_w + 1)'(byte_count)
                + (frontend_pkg::count_w + 1)'(log_count)
                * (frontend_pkg::count_w + 1)'(frontend_pkg::block_bytes)
                + (frontend_pkg::count_w + 1)'(frontend_pkg::block_bytes);
    assign space_ok = (need <= (frontend_pkg::count_w + 1)'(frontend_pkg::buf_bytes));

    // The reservation only grows on acceptance, so req_valid holds until then.
    // The space rule alone caps the log at max_outstanding entries.
    assign req_valid = started && space_ok;
    assign req_addr  = fetch_addr;
    assign req_id    = next_id;
    assign log_push  = req_valid && req_accept;

    // Only the oldest outstanding reply fits the buffer order.
    // Anything else is dropped.
    assign log_pop   = rsp_valid && !log_empty && (rsp_id == log_head);
    assign blk_write = log_pop;
    assign blk_data  = rsp_data;

    always_ff @(posedge clk) begin
        if (ht_rst || redirect) begin
            started    <= 1'b0;
            fetch_addr <= pc;
        end else begin
            started <= 1'b1;
            if (log_push) begin
                fetch_addr <= fetch_addr + frontend_pkg::addr_w'(frontend_pkg::block_bytes);
            end
        end
    end

    // Ids keep counting across a redirect.
    // Replies to flushed requests then never match a new log entry.
    always_ff @(posedge clk) begin
        if (ht_rst) begin
            next_id <= frontend_pkg::id_w'(1);
        end else if (log_push) begin
            // Id 0 is never issued.
            next_id <= (next_id == '1) ? frontend_pkg::id_w'(1) : next_id + 1'b1;
        end
    end

    // Ids of requests in flight, oldest at the head.
    sync_fifo #(
        .item_t (logic [frontend_pkg::id_w-1:0]),
        .depth  (frontend_pkg::max_outstanding)
    ) request_log_inst (
        .clk     (clk),
        .ht_rst  (ht_rst),
        .flush   (redirect),
        .push    (log_push),
        .wr_item (next_id),
        .pop     (log_pop),
        .rd_item (log_head),
        .full    (),
        .empty   (log_empty),
        .count   (log_count)
    );

endmodule

// ==== rtl/decode_byte_buffer.sv ====
`timescale 1ns/1ps

module decode_byte_buffer (
    input  logic                                    clk,
    input  logic                                    ht_rst,
    input  logic                                    redirect,
    input  logic                                    blk_write,
    input  frontend_pkg::block_t                    blk_data,
    input  logic                                    shift_en,
    input  logic [frontend_pkg::len_w-1:0]          shift_amount,
    output logic [frontend_pkg::count_w-1:0]        byte_count,
    output logic [frontend_pkg::inst_bytes*8-1:0]   head_bytes
);

    // Byte 0 is the oldest byte, the next one to decode.
    logic [7:0] bytes_q [frontend_pkg::buf_bytes];
    logic [7:0] bytes_d [frontend_pkg::buf_bytes];

    logic [frontend_pkg::count_w-1:0] count_q;
    logic [frontend_pkg::count_w-1:0] kept;
    logic [frontend_pkg::count_w-1:0] count_d;

    // Bytes left after the shift, then the appended block on top.
    assign kept    = shift_en ? count_q - frontend_pkg::count_w'(shift_amount) : count_q;
    assign count_d = blk_write ? kept + frontend_pkg::count_w'(frontend_pkg::block_bytes)
                               : kept;

    always_comb begin
        int src;
        for (int i = 0; i < frontend_pkg::buf_bytes; i++) begin
            src = shift_en ? i + int'(shift_amount) : i;
            if (i < int'(kept)) begin
                // Surviving byte moves down by the shift amount.
                bytes_d[i] = bytes_q[src];
            end else if (blk_write && (i < int'(kept) + frontend_pkg::block_bytes)) begin
                // New block lands right after the kept bytes.
                bytes_d[i] = blk_data[8*(i - int'(kept)) +: 8];
            end else begin
                // Freed entry.
                bytes_d[i] = '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ht_rst || redirect) begin
            count_q <= '0;
            for (int i = 0; i < frontend_pkg::buf_bytes; i++) begin
                bytes_q[i] <= '0;
            end
        end else begin
            count_q <= count_d;
            bytes_q <= bytes_d;
        end
    end

    assign byte_count = count_q;

    // First bytes go to the length decoder.
    always_comb begin
        for (int b = 0; b < frontend_pkg::inst_bytes; b++) begin
            head_bytes[8*b +: 8] = bytes_q[b];
        end
    end

endmodule

// ==== rtl/length_decoder.sv ====
`timescale 1ns/1ps

module length_decoder (
    input  logic                                    clk,
    input  logic                                    ht_rst,
    input  logic [frontend_pkg::addr_w-1:0]         pc,
    input  logic                                    redirect,
    input  logic [frontend_pkg::count_w-1:0]        byte_count,
    input  logic [frontend_pkg::inst_bytes*8-1:0]   head_bytes,
    input  logic                                    queue_full,
    output logic                                    shift_en,
    output logic [frontend_pkg::len_w-1:0]          shift_amount,
    output logic                                    push,
    output frontend_pkg::inst_t                     record
);

    logic [7:0]                            first_byte;
    logic [frontend_pkg::len_w-1:0]        inst_len;
    logic                                  len_valid;
    logic                                  fire;
    logic [frontend_pkg::addr_w-1:0]       inst_addr;
    logic [frontend_pkg::inst_bytes*8-1:0] inst_data;

    assign first_byte = head_bytes[7:0];

    // Class from bits 2:0, format from bits 4:3.
    always_comb begin
        inst_len  = '0;
        len_valid = 1'b0;
        case (first_byte[2:0])
            frontend_pkg::class_alu: begin
                len_valid = 1'b1;
                // Bit 3 marks the immediate form.
                inst_len  = first_byte[3] ? frontend_pkg::len_alu_imm
                                          : frontend_pkg::len_alu_reg;
            end
            frontend_pkg::class_mio: begin
                case (first_byte[4:3])
                    2'b00: begin
                        len_valid = 1'b1;
                        inst_len  = frontend_pkg::len_mio_long;
                    end
                    2'b01: begin
                        len_valid = 1'b1;
                        inst_len  = frontend_pkg::len_mio_short;
                    end
                    2'b10: begin
                        len_valid = 1'b1;
                        inst_len  = frontend_pkg::len_mio_mid;
                    end
                    // 11 is reserved and stalls decode.
                    default: begin
                        len_valid = 1'b0;
                    end
                endcase
            end
            frontend_pkg::class_pfcu: begin
                len_valid = 1'b1;
                inst_len  = first_byte[3] ? frontend_pkg::len_pfcu_long
                                          : frontend_pkg::len_pfcu;
            end
            default: begin
                len_valid = 1'b0;
            end
        endcase
    end

    // Whole instruction present and room in the queue.
    // An invalid first byte never fires, so decode waits for a redirect.
    assign fire = len_valid
               && (byte_count >= (frontend_pkg::count_w)'(inst_len))
               && !queue_full;

    // Keep only the instruction's own bytes.
    always_comb begin
        for (int b = 0; b < frontend_pkg::inst_bytes; b++) begin
            inst_data[8*b +: 8] = (b < int'(inst_len)) ? head_bytes[8*b +: 8] : 8'h00;
        end
    end

    // Push and shift share the edge, one instruction per cycle.
    assign push         = fire;
    assign shift_en     = fire;
    assign shift_amount = inst_len;
    assign record       = '{data: inst_data, addr: inst_addr, len: inst_len};

    // Address of the byte at the buffer head.
    always_ff @(posedge clk) begin
        if (ht_rst || redirect) begin
            inst_addr <= pc;
        end else if (fire) begin
            inst_addr <= inst_addr + frontend_pkg::addr_w'(inst_len);
        end
    end

endmodule

// ==== rtl/instruction_frontend.sv ====
`timescale 1ns/1ps

module instruction_frontend (
    input  logic                                    clk,
    input  logic                                    ht_rst,
    input  logic [frontend_pkg::addr_w-1:0]         pc,
    input  logic                                    redirect,
    output logic                                    req_valid,
    output logic [frontend_pkg::addr_w-1:0]         req_addr,
    output logic [frontend_pkg::id_w-1:0]           req_id,
    input  logic                                    req_accept,
    input  logic                                    rsp_valid,
    input  logic [frontend_pkg::id_w-1:0]           rsp_id,
    input  frontend_pkg::block_t                    rsp_data,
    output logic                                    inst_present,
    output logic [frontend_pkg::inst_bytes*8-1:0]   inst_data,
    output logic [frontend_pkg::addr_w-1:0]         inst_addr,
    output logic [frontend_pkg::len_w-1:0]          inst_len,
    input  logic                                    inst_next
);

    // Fetch unit to byte buffer.
    logic                                  blk_write;
    frontend_pkg::block_t                  blk_data;
    // Byte buffer to decoder, and back.
    logic [frontend_pkg::count_w-1:0]      byte_count;
    logic [frontend_pkg::inst_bytes*8-1:0] head_bytes;
    logic                                  shift_en;
    logic [frontend_pkg::len_w-1:0]        shift_amount;
    // Decoder to instruction queue.
    logic                                  push;
    frontend_pkg::inst_t                   record;
    frontend_pkg::inst_t                   queue_head;
    logic                                  queue_full;
    logic                                  queue_empty;

    fetch_unit fetch_unit_inst (
        .clk        (clk),
        .ht_rst     (ht_rst),
        .pc         (pc),
        .redirect   (redirect),
        .byte_count (byte_count),
        .req_valid  (req_valid),
        .req_addr   (req_addr),
        .req_id     (req_id),
        .req_accept (req_accept),
        .rsp_valid  (rsp_valid),
        .rsp_id     (rsp_id),
        .rsp_data   (rsp_data),
        .blk_write  (blk_write),
        .blk_data   (blk_data)
    );

    decode_byte_buffer decode_byte_buffer_inst (
        .clk          (clk),
        .ht_rst       (ht_rst),
        .redirect     (redirect),
        .blk_write    (blk_write),
        .blk_data     (blk_data),
        .shift_en     (shift_en),
        .shift_amount (shift_amount),
        .byte_count   (byte_count),
        .head_bytes   (head_bytes)
    );

    length_decoder length_decoder_inst (
        .clk          (clk),
        .ht_rst       (ht_rst),
        .pc           (pc),
        .redirect     (redirect),
        .byte_count   (byte_count),
        .head_bytes   (head_bytes),
        .queue_full   (queue_full),
        .shift_en     (shift_en),
        .shift_amount (shift_amount),
        .push         (push),
        .record       (record)
    );

    // Decoded instructions waiting for the next stage.
    sync_fifo #(
        .item_t (frontend_pkg::inst_t),
        .depth  (frontend_pkg::queue_depth)
    ) inst_queue_inst (
        .clk     (clk),
        .ht_rst  (ht_rst),
        .flush   (redirect),
        .push    (push),
        .wr_item (record),
        .pop     (inst_next),
        .rd_item (queue_head),
        .full    (queue_full),
        .empty   (queue_empty),
        .count   ()
    );

    assign inst_present = !queue_empty;
    assign inst_data    = queue_head.data;
    assign inst_addr    = queue_head.addr;
    assign inst_len     = queue_head.len;

endmodule

// ==== test/frontend_assertions.sv ====
`timescale 1ns/1ps

module frontend_assertions (
    input logic                            clk,
    input logic                            ht_rst,
    input logic                            redirect,
    input logic                            req_valid,
    input logic [frontend_pkg::addr_w-1:0] req_addr,
    input logic                            req_accept,
    input logic                            inst_present
);

    // A pending request holds until accepted, unless a redirect cancels it.
    property req_held;
        @(posedge clk) disable iff (ht_rst)
        (req_valid && !req_accept && !redirect) |=> req_valid;
    endproperty

    property req_addr_stable;
        @(posedge clk) disable iff (ht_rst)
        (req_valid && !req_accept && !redirect) |=> $stable(req_addr);
    endproperty

    // Queue is empty from the second reset edge on.
    property no_inst_in_reset;
        @(posedge clk) (ht_rst && $past(ht_rst)) |-> !inst_present;
    endproperty

    req_held_a: assert property (req_held)
        else $error("req_valid dropped before acceptance");
    req_addr_a: assert property (req_addr_stable)
        else $error("req_addr changed before acceptance");
    reset_a: assert property (no_inst_in_reset)
        else $error("inst_present high during reset");

endmodule

bind instruction_frontend frontend_assertions frontend_assertions_inst (
    .clk          (clk),
    .ht_rst       (ht_rst),
    .redirect     (redirect),
    .req_valid    (req_valid),
    .req_addr     (req_addr),
    .req_accept   (req_accept),
    .inst_present (inst_present)
);

// ==== test/tb_instruction_frontend.sv ====
`timescale 1ns/1ps

module tb_instruction_frontend;

    logic        clk = 1'b0;
    logic        ht_rst;
    logic [31:0] pc;
    logic        redirect;
    logic        req_valid;
    logic [31:0] req_addr;
    logic [7:0]  req_id;
    logic        req_accept;
    logic        rsp_valid;
    logic [7:0]  rsp_id;
    logic [127:0] rsp_data;
    logic        inst_present;
    logic [47:0] inst_data;
    logic [31:0] inst_addr;
    logic [2:0]  inst_len;
    logic        inst_next;

    // Test table, one row per program.
    string      names [6];
    logic [31:0] start_pc [6];
    logic [7:0] first_bytes [6][12];
    int         exp_count [6];
    bit         slow [6];
    bit         bogus [6];
    bit         redir [6];
    bit         burst [6];

    // Memory image holds first bytes, all other bytes come from fill_byte.
    logic [7:0] img [int unsigned];
    // Accepted requests waiting for a reply, oldest first.
    logic [7:0]  pend_id [$];
    logic [31:0] pend_addr [$];
    int          pend_due [$];
    bit          pend_stale [$];
    // Records the DUT should produce, in order.
    logic [47:0] exp_data [$];
    logic [31:0] exp_addr [$];
    logic [2:0]  exp_len [$];

    string       test_name = "reset";
    int          cyc = 0;
    int          live = 0;
    int          peak = 0;
    int          received = 0;
    int          hold_cnt = 0;
    logic [31:0] exp_fetch = 0;
    logic [7:0]  exp_id = 8'h01;
    bit          active = 0;
    bit          consume = 0;
    bit          slow_now = 0;
    bit          bogus_now = 0;
    bit          burst_now = 0;
    bit          drive_redirect = 0;
    logic [31:0] drive_pc = 0;

    always #5 clk = ~clk;

    instruction_frontend instruction_frontend_inst (.*);

    task automatic check_value(string what, logic [63:0] expected, logic [63:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s %s: expected %h, actual %h", test_name, what, expected, actual);
            $display("Result: FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic fail_plain(string msg);
        $display("%s in test %s", msg, test_name);
        $display("Result: FAILED");
        $fatal(1, "run aborted");
    endtask

    // Background bytes mix every address bit.
    function automatic logic [7:0] fill_byte(logic [31:0] a);
        return (a[7:0] * 8'd7) ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'ha5;
    endfunction

    function automatic logic [7:0] img_byte(logic [31:0] a);
        return img.exists(a) ? img[a] : fill_byte(a);
    endfunction

    // Length rules, 0 marks an undecodable byte.
    function automatic int model_len(logic [7:0] b);
        case (b[2:0])
            3'b100: return b[3] ? 6 : 2;
            3'b010: begin
                case (b[4:3])
                    2'b00: return 6;
                    2'b01: return 2;
                    2'b10: return 3;
                    default: return 0;
                endcase
            end
            3'b110: return b[3] ? 5 : 1;
            default: return 0;
        endcase
    endfunction

    // Lays a row's program into the image and fills the expected records.
    task automatic build_program(int r, logic [31:0] base);
        logic [31:0] a;
        logic [47:0] d;
        int          len;
        int          n;
        a = base;
        n = 0;
        exp_data.delete();
        exp_addr.delete();
        exp_len.delete();
        received = 0;
        for (int k = 0; k < 12; k++) begin
            img[a] = first_bytes[r][k];
            len = model_len(first_bytes[r][k]);
            if (len == 0) break;
            d = '0;
            for (int j = 0; j < len; j++) begin
                d[8*j +: 8] = img_byte(a + j);
            end
            exp_data.push_back(d);
            exp_addr.push_back(a);
            exp_len.push_back(3'(len));
            a = a + len;
            n++;
            // Terminator stalls decode after a fully valid program.
            if (k == 11) img[a] = 8'h00;
        end
        check_value("model count", exp_count[r], n);
    endtask

    // One cycle: drive at the falling edge, sample just before the rising edge.
    task automatic step();
        logic [127:0] blk;
        bit           hold;
        @(negedge clk);
        cyc++;
        redirect   = drive_redirect;
        pc         = drive_pc;
        req_accept = active && (burst_now || ($urandom % 4 != 0));
        rsp_valid  = 1'b0;
        rsp_id     = '0;
        rsp_data   = '0;
        hold = burst_now && live < 4 && hold_cnt < 30;
        if (hold) hold_cnt++;
        if (pend_id.size() > 0 && pend_due[0] <= cyc && !hold) begin
            for (int j = 0; j < 16; j++) begin
                blk[8*j +: 8] = img_byte(pend_addr[0] + j);
            end
            rsp_valid = 1'b1;
            rsp_id    = pend_id[0];
            rsp_data  = blk;
            if (!pend_stale[0]) live--;
            void'(pend_id.pop_front());
            void'(pend_addr.pop_front());
            void'(pend_due.pop_front());
            void'(pend_stale.pop_front());
        end else if (bogus_now && active && ($urandom % 5 == 0)) begin
            // Id 0 is never issued, so nothing waits for it.
            rsp_valid = 1'b1;
            rsp_id    = 8'h00;
            rsp_data  = {$urandom, $urandom, $urandom, $urandom};
        end
        inst_next = consume && !drive_redirect
                  && (slow_now ? ($urandom % 8 == 0) : ($urandom % 4 != 0));
        #4;
        if (req_valid && req_accept) begin
            // Ids run from 1 to 255 and keep counting across a redirect.
            check_value("req_id", exp_id, req_id);
            exp_id = (exp_id == 8'hff) ? 8'h01 : exp_id + 8'h01;
        end
        if (redirect) begin
            foreach (pend_stale[i]) pend_stale[i] = 1'b1;
            live = 0;
            exp_fetch = pc;
            if (req_valid && req_accept) begin
                pend_id.push_back(req_id);
                pend_addr.push_back(req_addr);
                pend_due.push_back(cyc + 1);
                pend_stale.push_back(1'b1);
            end
        end else if (req_valid && req_accept) begin
            check_value("req_addr", exp_fetch, req_addr);
            exp_fetch = exp_fetch + 16;
            pend_id.push_back(req_id);
            pend_addr.push_back(req_addr);
            pend_due.push_back(cyc + 1 + int'($urandom % 6));
            pend_stale.push_back(1'b0);
            live++;
            check_value("outstanding within limit", 1, live <= 4);
            if (live > peak) peak = live;
        end
        if (inst_present && inst_next && !redirect) begin
            if (exp_data.size() == 0) fail_plain("Unexpected instruction popped");
            check_value("inst_data", exp_data.pop_front(), inst_data);
            check_value("inst_addr", exp_addr.pop_front(), inst_addr);
            check_value("inst_len", exp_len.pop_front(), inst_len);
            received++;
        end
    endtask

    task automatic pulse_redirect(logic [31:0] new_pc);
        drive_redirect = 1'b1;
        drive_pc = new_pc;
        step();
        drive_redirect = 1'b0;
    endtask

    task automatic wait_records(int n);
        int t;
        for (t = 0; t < 3000 && received < n; t++) step();
        if (received < n) fail_plain("Timed out waiting for instructions");
    endtask

    task automatic load_table();
        names[0] = "mixed";
        start_pc[0] = 32'h0000_1000;
        exp_count[0] = 12;
        first_bytes[0] = '{8'h04, 8'h0c, 8'h02, 8'h0a, 8'h12, 8'h06,
                           8'h0e, 8'he4, 8'h8c, 8'h52, 8'hf6, 8'h3e};
        names[1] = "slow_consumer";
        start_pc[1] = 32'h0000_2003;
        exp_count[1] = 12;
        first_bytes[1] = '{8'h0e, 8'h0c, 8'h02, 8'h0c, 8'h0e, 8'h02,
                           8'h0c, 8'h0e, 8'h02, 8'h0c, 8'h02, 8'h0e};
        names[2] = "bogus_reply";
        start_pc[2] = 32'h0000_3000;
        exp_count[2] = 12;
        first_bytes[2] = '{8'h06, 8'h06, 8'h12, 8'h0a, 8'h04, 8'he6,
                           8'h26, 8'h0c, 8'h46, 8'h12, 8'h0a, 8'h04};
        names[3] = "redirect";
        start_pc[3] = 32'h0000_4100;
        exp_count[3] = 12;
        first_bytes[3] = first_bytes[0];
        // 0x1a is memory class with reserved format 11.
        names[4] = "invalid_stall";
        start_pc[4] = 32'h0000_5000;
        exp_count[4] = 2;
        first_bytes[4] = '{8'h04, 8'h0a, 8'h1a, 8'h04, 8'h04, 8'h04,
                           8'h04, 8'h04, 8'h04, 8'h04, 8'h04, 8'h04};
        names[5] = "burst";
        start_pc[5] = 32'h0000_6008;
        exp_count[5] = 12;
        first_bytes[5] = first_bytes[2];
        slow  = '{0, 1, 0, 0, 0, 0};
        bogus = '{0, 0, 1, 0, 0, 0};
        redir = '{0, 0, 0, 1, 0, 0};
        burst = '{0, 0, 0, 0, 0, 1};
    endtask

    initial begin
        ht_rst = 1'b1;
        pc = '0;
        redirect = 1'b0;
        req_accept = 1'b0;
        rsp_valid = 1'b0;
        rsp_id = '0;
        rsp_data = '0;
        inst_next = 1'b0;
        void'($urandom(60));
        load_table();
        // Two rising edges in reset, released on the falling edge after them.
        repeat (2) @(posedge clk);
        @(negedge clk);
        ht_rst = 1'b0;
        for (int r = 0; r < 6; r++) begin
            test_name = names[r];
            slow_now  = slow[r];
            bogus_now = bogus[r];
            burst_now = burst[r];
            hold_cnt  = 0;
            peak      = 0;
            active    = 1'b1;
            consume   = 1'b1;
            if (redir[r]) begin
                // Stream a decoy program, then leave it mid-flight.
                build_program(r, 32'h0000_9000);
                pulse_redirect(32'h0000_9000);
                wait_records(3);
            end
            build_program(r, start_pc[r]);
            pulse_redirect(start_pc[r]);
            wait_records(exp_count[r]);
            // Decode must stay stalled at the undecodable byte.
            for (int t = 0; t < 40; t++) begin
                step();
                check_value("inst_present after stall", 0, inst_present);
            end
            if (burst[r]) check_value("peak outstanding", 4, peak);
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

// ==== list.f ====
rtl/frontend_pkg.sv
rtl/sync_fifo.sv
rtl/fetch_unit.sv
rtl/decode_byte_buffer.sv
rtl/length_decoder.sv
rtl/instruction_frontend.sv
test/frontend_assertions.sv
test/tb_instruction_frontend.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wall -Wno-fatal \
    -f list.f --top-module tb_instruction_frontend -o sim_frontend

# The exit status is ignored here so that the log search decides the result.
./obj_dir/sim_frontend > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
    echo "Simulation ended without a result line"
    exit 1
fi
